/* files.f */
verilog/rv_pkg.sv
verilog/rv_fetch.sv
verilog/rv_decode.sv
verilog/rv_regfile.sv
verilog/rv_execute.sv
verilog/rv_result.sv
verilog/rv_core.sv
tests/rv_core_assertions.sv
tests/rv_core_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the RV32I core testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module rv_core_tb -f files.f -o rv_core_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/rv_core_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Testbench failed" "$log"; then
   exit 1
fi
exit 0

/* tests/rv_core_assertions.sv */
module rv_core_assertions (
   input logic        clk,
   input logic        i_rst_n,
   input logic        i_wb_cyc,
   input logic        i_wb_stb,
   input logic [31:0] i_wb_adr,
   input logic        i_wb_ack,
   input logic        i_retire,
   input logic        i_halt
);
   timeunit 1ns;
   timeprecision 1ps;

   // Cycle and strobe stay up together until the slave acks
   stb_held: assert property (@(posedge clk) disable iff (!i_rst_n)
      (i_wb_cyc && !i_wb_ack) |=> (i_wb_cyc && i_wb_stb))
      else $error("Wishbone cycle dropped before the ack");

   // Address held while the slave has not acked
   adr_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
      (i_wb_stb && !i_wb_ack) |=> $stable(i_wb_adr))
      else $error("Wishbone address changed while stb was waiting");

   // Retire is visible the cycle after commit and two edges after ack
   retire_after_ack: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_retire == $past(i_wb_cyc && i_wb_ack, 2))
      else $error("Retire pulse does not line up with a Wishbone ack");

   no_fetch_halted: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_halt |-> !i_wb_cyc)
      else $error("Wishbone cycle started while the core is halted");

endmodule

bind rv_core rv_core_assertions u_assertions (
   .clk(clk), .i_rst_n(i_rst_n),
   .i_wb_cyc(o_wb_cyc), .i_wb_stb(o_wb_stb), .i_wb_adr(o_wb_adr), .i_wb_ack(i_wb_ack),
   .i_retire(o_retire), .i_halt(o_halt)
);

/* tests/rv_core_tb.sv */
module rv_core_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam logic [31:0] RESET_PC  = 32'h0000_0080;
   localparam logic [7:0]  BASE_WORD = RESET_PC[9:2];
   // Retired instructions over all programs
   localparam int INSTR_COUNT = 15 + 15 + 18 + 9 + 2;
   // Up to 6 cycles per fetch and a 4x margin
   localparam int CYCLE_LIMIT = 4 * INSTR_COUNT * 6;

   // Major opcodes from the RV32I encoding
   localparam int OP_IMM = 'b0010011;
   localparam int LUI    = 'b0110111;
   localparam int AUIPC  = 'b0010111;
   localparam int JALR   = 'b1100111;
   localparam logic [31:0] ECALL = 32'h0000_0073;

   logic        clk;
   logic        i_rst_n;
   logic        o_wb_cyc;
   logic        o_wb_stb;
   logic [31:0] o_wb_adr;
   logic [31:0] i_wb_dat;
   logic        i_wb_ack;
   logic        o_retire;
   logic [31:0] o_retire_pc;
   logic [4:0]  o_retire_rd;
   logic [31:0] o_retire_data;
   logic        o_halt;

   logic [31:0] mem [0:255];
   logic [31:0] prog [$];
   logic [31:0] ref_x [0:31];
   logic [31:0] ref_pc;
   int          errors;
   int          checks;
   int          cycles = 0;
   integer      seed = 18441;
   logic        stb_seen;
   logic [31:0] adr_seen;
   logic [1:0]  wait_cnt;
   logic [31:0] rnd;

   rv_core #(.RESET_PC(RESET_PC)) dut_i (
      .clk(clk), .i_rst_n(i_rst_n),
      .o_wb_cyc(o_wb_cyc), .o_wb_stb(o_wb_stb), .o_wb_adr(o_wb_adr),
      .i_wb_dat(i_wb_dat), .i_wb_ack(i_wb_ack),
      .o_retire(o_retire), .o_retire_pc(o_retire_pc), .o_retire_rd(o_retire_rd),
      .o_retire_data(o_retire_data), .o_halt(o_halt)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Timeout after %0d cycles, the core stopped retiring", cycles);
         $display("Testbench failed");
         $finish;
      end
   end

   // Wishbone slave with 0 to 3 wait states per access
   initial begin
      i_wb_ack = 1'b0;
      i_wb_dat = 32'h0;
      wait_cnt = 2'd0;
      forever begin
         @(negedge clk);
         stb_seen = o_wb_stb;
         adr_seen = o_wb_adr;
         @(posedge clk);
         if (i_wb_ack || !stb_seen) begin
            i_wb_ack <= 1'b0;
         end else if (wait_cnt == 2'd0) begin
            i_wb_ack <= 1'b1;
            i_wb_dat <= mem[adr_seen[9:2]];
            rnd = $random(seed);
            wait_cnt = rnd[1:0];
         end else begin
            wait_cnt = wait_cnt - 2'd1;
         end
      end
   end

   function automatic logic [31:0] r_type(input int f7, rs2, rs1, f3, rd);
      return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
   endfunction

   function automatic logic [31:0] i_type(input int imm, rs1, f3, rd, op);
      return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
   endfunction

   function automatic logic [31:0] u_type(input int imm, rd, op);
      return {imm[19:0], rd[4:0], op[6:0]};
   endfunction

   function automatic logic [31:0] b_type(input int off, rs2, rs1, f3);
      return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'b1100011};
   endfunction

   function automatic logic [31:0] j_type(input int off, rd);
      return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
   endfunction

   task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("FAIL %s exp %h act %h", name, exp, act);
      end
   endtask

   // Architectural model steps one instruction from mem at ref_pc
   task automatic model_step(output logic [4:0] rd_o, output logic [31:0] val_o,
                             output logic ill);
      logic [31:0] ins;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] imm_i;
      logic [31:0] res;
      logic [31:0] nxt;
      logic [4:0]  rd;
      logic [2:0]  f3;
      logic        wr;
      logic        take;
      ins   = mem[ref_pc[9:2]];
      rd    = ins[11:7];
      f3    = ins[14:12];
      a     = ref_x[ins[19:15]];
      b     = ref_x[ins[24:20]];
      imm_i = {{20{ins[31]}}, ins[31:20]};
      nxt   = ref_pc + 32'd4;
      res   = 32'h0;
      wr    = 1'b1;
      ill   = 1'b0;
      take  = 1'b0;
      case (ins[6:0])
         7'b0110011, 7'b0010011: begin
            if (!ins[5]) begin
               b = imm_i;
            end
            case (f3)
               3'd0: res = (ins[5] && ins[30]) ? a - b : a + b;
               3'd1: res = a << b[4:0];
               3'd2: res = ($signed(a) < $signed(b)) ? 32'h1 : 32'h0;
               3'd3: res = (a < b) ? 32'h1 : 32'h0;
               3'd4: res = a ^ b;
               3'd5: res = ins[30] ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
               3'd6: res = a | b;
               default: res = a & b;
            endcase
         end
         7'b0110111: res = {ins[31:12], 12'h0};
         7'b0010111: res = ref_pc + {ins[31:12], 12'h0};
         7'b1101111: begin
            res = ref_pc + 32'd4;
            nxt = ref_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
         end
         7'b1100111: begin
            res = ref_pc + 32'd4;
            nxt = (a + imm_i) & 32'hffff_fffe;
         end
         7'b1100011: begin
            wr = 1'b0;
            case (f3)
               3'd0: take = (a == b);
               3'd1: take = (a != b);
               3'd4: take = ($signed(a) < $signed(b));
               3'd5: take = ($signed(a) >= $signed(b));
               3'd6: take = (a < b);
               3'd7: take = (a >= b);
               default: ill = 1'b1;
            endcase
            if (take) begin
               nxt = ref_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            end
         end
         default: ill = 1'b1;
      endcase
      if (ill || rd == 5'd0) begin
         wr = 1'b0;
      end
      rd_o  = wr ? rd : 5'd0;
      val_o = wr ? res : 32'h0;
      if (wr) begin
         ref_x[rd] = res;
      end
      ref_pc = nxt;
   endtask

   // Loads prog, resets the core and follows it until it halts
   task automatic run_program();
      logic [31:0] pc;
      logic [4:0]  rd;
      logic [31:0] val;
      logic        ill;
      for (int i = 0; i < 256; i++) begin
         mem[i[7:0]] = {8'hbd, 14'h0, i[7:0], 2'b00};
      end
      for (int k = 0; k < prog.size(); k++) begin
         mem[BASE_WORD + k[7:0]] = prog[k];
      end
      prog.delete();
      ref_pc = RESET_PC;
      ref_x  = '{default: 32'h0};
      @(posedge clk);
      i_rst_n <= 1'b0;
      repeat (5) @(posedge clk);
      i_rst_n <= 1'b1;
      @(posedge clk);
      @(negedge clk);
      // First cycle out of reset
      check("o_wb_cyc", 32'h1, {31'h0, o_wb_cyc});
      check("o_wb_stb", 32'h1, {31'h0, o_wb_stb});
      check("o_wb_adr", RESET_PC, o_wb_adr);
      check("o_retire", 32'h0, {31'h0, o_retire});
      check("o_halt", 32'h0, {31'h0, o_halt});
      ill = 1'b0;
      while (!ill) begin
         @(negedge clk);
         while (!o_retire) begin
            @(negedge clk);
         end
         pc = ref_pc;
         model_step(rd, val, ill);
         check("o_retire_pc", pc, o_retire_pc);
         check("o_retire_rd", {27'h0, rd}, {27'h0, o_retire_rd});
         check("o_retire_data", val, o_retire_data);
         check("o_halt", {31'h0, ill}, {31'h0, o_halt});
      end
   endtask

   task automatic arith_logic_test();
      prog.push_back(i_type(100, 0, 0, 1, OP_IMM));
      prog.push_back(i_type(-37, 0, 0, 2, OP_IMM));
      prog.push_back(r_type(0, 2, 1, 0, 3));
      prog.push_back(r_type(32, 1, 2, 0, 4));
      prog.push_back(r_type(0, 2, 1, 7, 5));
      prog.push_back(r_type(0, 2, 1, 6, 6));
      prog.push_back(r_type(0, 2, 1, 4, 7));
      prog.push_back(r_type(0, 1, 2, 2, 8));
      prog.push_back(r_type(0, 1, 2, 3, 9));
      prog.push_back(i_type(-1, 2, 2, 10, OP_IMM));
      prog.push_back(i_type(-1, 1, 3, 11, OP_IMM));
      prog.push_back(i_type(-256, 1, 4, 12, OP_IMM));
      prog.push_back(i_type('h70f, 2, 6, 13, OP_IMM));
      prog.push_back(i_type(-16, 2, 7, 14, OP_IMM));
      prog.push_back(ECALL);
      run_program();
   endtask

   task automatic shift_upper_test();
      prog.push_back(u_type('h80f0f, 1, LUI));
      prog.push_back(i_type('h123, 1, 0, 1, OP_IMM));
      prog.push_back(i_type(7, 0, 0, 2, OP_IMM));
      prog.push_back(r_type(0, 2, 1, 1, 3));
      prog.push_back(r_type(0, 2, 1, 5, 4));
      prog.push_back(r_type(32, 2, 1, 5, 5));
      // Only the low 5 bits of the amount count
      prog.push_back(i_type(35, 0, 0, 6, OP_IMM));
      prog.push_back(r_type(0, 6, 1, 1, 7));
      prog.push_back(i_type(31, 1, 1, 8, OP_IMM));
      prog.push_back(i_type(4, 1, 5, 9, OP_IMM));
      prog.push_back(i_type('h400 + 12, 1, 5, 10, OP_IMM));
      prog.push_back(u_type('hfffff, 11, LUI));
      prog.push_back(u_type('h12345, 12, AUIPC));
      prog.push_back(u_type(0, 13, AUIPC));
      prog.push_back(ECALL);
      run_program();
   endtask

   task automatic control_flow_test();
      logic [31:0] skip;
      // Must never retire
      skip = i_type(1, 31, 0, 31, OP_IMM);
      prog.push_back(i_type(-5, 0, 0, 1, OP_IMM));
      prog.push_back(i_type(3, 0, 0, 2, OP_IMM));
      // Each condition taken, then not taken
      prog.push_back(b_type(8, 1, 1, 0));
      prog.push_back(skip);
      prog.push_back(b_type(8, 2, 1, 0));
      prog.push_back(b_type(8, 2, 1, 1));
      prog.push_back(skip);
      prog.push_back(b_type(8, 1, 1, 1));
      prog.push_back(b_type(8, 2, 1, 4));
      prog.push_back(skip);
      prog.push_back(b_type(8, 1, 2, 4));
      prog.push_back(b_type(8, 1, 2, 5));
      prog.push_back(skip);
      prog.push_back(b_type(8, 2, 1, 5));
      prog.push_back(b_type(8, 1, 2, 6));
      prog.push_back(skip);
      prog.push_back(b_type(8, 2, 1, 6));
      prog.push_back(b_type(8, 2, 1, 7));
      prog.push_back(skip);
      prog.push_back(b_type(8, 1, 2, 7));
      prog.push_back(j_type(12, 5));
      prog.push_back(skip);
      prog.push_back(skip);
      // Odd sum so the target needs bit 0 cleared
      prog.push_back(i_type(21, 5, 0, 7, JALR));
      prog.push_back(skip);
      prog.push_back(skip);
      prog.push_back(r_type(0, 5, 7, 0, 8));
      prog.push_back(ECALL);
      run_program();
   endtask

   task automatic zero_reg_test();
      prog.push_back(i_type(55, 0, 0, 0, OP_IMM));
      prog.push_back(i_type(9, 0, 0, 1, OP_IMM));
      prog.push_back(r_type(0, 1, 1, 0, 0));
      prog.push_back(u_type('h12345, 0, LUI));
      prog.push_back(i_type(1, 0, 0, 2, OP_IMM));
      prog.push_back(r_type(0, 0, 0, 0, 3));
      prog.push_back(j_type(4, 0));
      prog.push_back(r_type(0, 1, 0, 6, 4));
      prog.push_back(ECALL);
      run_program();
   endtask

   task automatic illegal_opcode_test();
      prog.push_back(i_type(1, 0, 0, 1, OP_IMM));
      prog.push_back(ECALL);
      prog.push_back(i_type(1, 1, 0, 1, OP_IMM));
      run_program();
      // Core stays stopped
      repeat (20) begin
         @(negedge clk);
         check("o_wb_cyc", 32'h0, {31'h0, o_wb_cyc});
         check("o_retire", 32'h0, {31'h0, o_retire});
         check("o_halt", 32'h1, {31'h0, o_halt});
      end
   endtask

   initial begin
      i_rst_n = 1'b0;
      errors  = 0;
      checks  = 0;
      arith_logic_test();
      shift_upper_test();
      control_flow_test();
      zero_reg_test();
      illegal_opcode_test();
      $display("Checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

/* verilog/rv_core.sv */
module rv_core #(
   parameter logic [31:0] RESET_PC = 32'h0
) (
   input  logic        clk,
   input  logic        i_rst_n,
   output logic        o_wb_cyc,
   output logic        o_wb_stb,
   output logic [31:0] o_wb_adr,
   input  logic [31:0] i_wb_dat,
   input  logic        i_wb_ack,
   output logic        o_retire,
   output logic [31:0] o_retire_pc,
   output logic [4:0]  o_retire_rd,
   output logic [31:0] o_retire_data,
   output logic        o_halt
);

   import rv_pkg::*;

   logic [31:0] instr;
   logic [31:0] instr_pc;
   logic        instr_valid;
   rv_dec_t     dec;
   rv_exe_t     exe;
   logic [31:0] rs1_data;
   logic [31:0] rs2_data;
   logic        rf_we;
   logic [4:0]  rf_rd;
   logic [31:0] rf_data;
   logic [31:0] next_pc;
   logic        next_valid;

   rv_fetch #(.RESET_PC(RESET_PC)) u_fetch (
      .clk(clk), .i_rst_n(i_rst_n),
      .i_next_pc(next_pc), .i_next_valid(next_valid), .i_halt(o_halt),
      .o_wb_cyc(o_wb_cyc), .o_wb_stb(o_wb_stb), .o_wb_adr(o_wb_adr),
      .i_wb_dat(i_wb_dat), .i_wb_ack(i_wb_ack),
      .o_instr(instr), .o_instr_pc(instr_pc), .o_instr_valid(instr_valid)
   );

   rv_decode u_decode (
      .clk(clk), .i_rst_n(i_rst_n),
      .i_instr(instr), .i_instr_pc(instr_pc), .i_instr_valid(instr_valid),
      .o_dec(dec)
   );

   rv_regfile u_regfile (
      .clk(clk), .i_rst_n(i_rst_n),
      .i_rs1(dec.rs1), .i_rs2(dec.rs2),
      .o_rs1_data(rs1_data), .o_rs2_data(rs2_data),
      .i_we(rf_we), .i_rd(rf_rd), .i_rd_data(rf_data)
   );

   rv_execute u_execute (
      .i_dec(dec), .i_rs1_data(rs1_data), .i_rs2_data(rs2_data), .o_exe(exe)
   );

   // Decode valid doubles as the commit strobe
   rv_result #(.RESET_PC(RESET_PC)) u_result (
      .clk(clk), .i_rst_n(i_rst_n),
      .i_exe(exe), .i_commit(dec.valid),
      .o_rf_we(rf_we), .o_rf_rd(rf_rd), .o_rf_data(rf_data),
      .o_next_pc(next_pc), .o_next_valid(next_valid),
      .o_retire(o_retire), .o_retire_pc(o_retire_pc),
      .o_retire_rd(o_retire_rd), .o_retire_data(o_retire_data),
      .o_halt(o_halt)
   );

endmodule

/* verilog/rv_decode.sv */
module rv_decode (
   input  logic             clk,
   input  logic             i_rst_n,
   input  logic [31:0]      i_instr,
   input  logic [31:0]      i_instr_pc,
   input  logic             i_instr_valid,
   output rv_pkg::rv_dec_t  o_dec
);

   import rv_pkg::*;

   logic [31:0] ir;
   logic [31:0] pc_q;
   logic        valid_q;

   rv_opcode_e  opcode;
   logic [2:0]  funct3;
   logic        imm30;
   logic [4:0]  rd;
   logic [31:0] imm_i;
   logic [31:0] imm_u;
   logic [31:0] imm_j;
   logic [31:0] imm_b;

   // Instruction register, payload only
   always_ff @(posedge clk) begin
      if (i_instr_valid) begin
         ir   <= i_instr;
         pc_q <= i_instr_pc;
      end
   end

   // Pulses for one cycle after each latch
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= i_instr_valid;
      end
   end

   assign opcode = rv_opcode_e'(ir[6:2]);
   assign funct3 = ir[14:12];
   assign imm30  = ir[30];
   assign rd     = ir[11:7];

   assign imm_i = {{20{ir[31]}}, ir[31:20]};
   assign imm_u = {ir[31:12], 12'b0};
   assign imm_j = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
   assign imm_b = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};

   always_comb begin
      o_dec           = '0;
      o_dec.valid     = valid_q;
      o_dec.rd        = rd;
      o_dec.rs1       = ir[19:15];
      o_dec.rs2       = ir[24:20];
      o_dec.pc        = pc_q;
      o_dec.br_funct3 = funct3;
      o_dec.alu_op    = ALU_ADD;
      o_dec.imm       = imm_i;

      case (funct3)
         3'b000:  o_dec.alu_op = (opcode == OPC_OP && imm30) ? ALU_SUB : ALU_ADD;
         3'b001:  o_dec.alu_op = ALU_SLL;
         3'b010:  o_dec.alu_op = ALU_SLT;
         3'b011:  o_dec.alu_op = ALU_SLTU;
         3'b100:  o_dec.alu_op = ALU_XOR;
         3'b101:  o_dec.alu_op = imm30 ? ALU_SRA : ALU_SRL;
         3'b110:  o_dec.alu_op = ALU_OR;
         default: o_dec.alu_op = ALU_AND;
      endcase

      case (opcode)
         OPC_OP: begin
            o_dec.rd_we = 1'b1;
         end
         OPC_OP_IMM: begin
            o_dec.rd_we    = 1'b1;
            o_dec.op_b_imm = 1'b1;
         end
         OPC_LUI: begin
            o_dec.rd_we    = 1'b1;
            o_dec.op_b_imm = 1'b1;
            o_dec.alu_op   = ALU_PASS_B;
            o_dec.imm      = imm_u;
         end
         OPC_AUIPC: begin
            o_dec.rd_we    = 1'b1;
            o_dec.op_a_pc  = 1'b1;
            o_dec.op_b_imm = 1'b1;
            o_dec.alu_op   = ALU_ADD;
            o_dec.imm      = imm_u;
         end
         OPC_JAL: begin
            o_dec.rd_we  = 1'b1;
            o_dec.is_jal = 1'b1;
            o_dec.imm    = imm_j;
         end
         OPC_JALR: begin
            o_dec.rd_we   = 1'b1;
            o_dec.is_jalr = 1'b1;
         end
         OPC_BRANCH: begin
            o_dec.is_branch = 1'b1;
            o_dec.imm       = imm_b;
            // funct3 010 and 011 are reserved
            o_dec.illegal   = (funct3[2:1] == 2'b01);
         end
         default: begin
            o_dec.illegal = 1'b1;
         end
      endcase

      // Compressed encodings are not supported
      if (ir[1:0] != 2'b11) begin
         o_dec.illegal = 1'b1;
      end
      if (rd == 5'd0 || o_dec.illegal) begin
         o_dec.rd_we = 1'b0;
      end
   end

endmodule

/* verilog/rv_execute.sv */
module rv_execute (
   input  rv_pkg::rv_dec_t  i_dec,
   input  logic [31:0]      i_rs1_data,
   input  logic [31:0]      i_rs2_data,
   output rv_pkg::rv_exe_t  o_exe
);

   import rv_pkg::*;

   logic [31:0] op_a;
   logic [31:0] op_b;
   logic [4:0]  shamt;
   logic [31:0] alu_res;
   logic        eq;
   logic        lt_s;
   logic        lt_u;
   logic        taken;
   logic [31:0] link;
   logic [31:0] jalr_sum;
   logic [31:0] target;

   assign op_a  = i_dec.op_a_pc ? i_dec.pc : i_rs1_data;
   assign op_b  = i_dec.op_b_imm ? i_dec.imm : i_rs2_data;
   assign shamt = op_b[4:0];

   always_comb begin
      case (i_dec.alu_op)
         ALU_ADD:    alu_res = op_a + op_b;
         ALU_SUB:    alu_res = op_a - op_b;
         ALU_SLL:    alu_res = op_a << shamt;
         ALU_SLT:    alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
         ALU_SLTU:   alu_res = {31'b0, op_a < op_b};
         ALU_XOR:    alu_res = op_a ^ op_b;
         ALU_SRL:    alu_res = op_a >> shamt;
         ALU_SRA:    alu_res = $unsigned($signed(op_a) >>> shamt);
         ALU_OR:     alu_res = op_a | op_b;
         ALU_AND:    alu_res = op_a & op_b;
         ALU_PASS_B: alu_res = op_b;
         default:    alu_res = 32'h0;
      endcase
   end

   // Branch comparator always works on rs1 and rs2
   assign eq   = (i_rs1_data == i_rs2_data);
   assign lt_s = ($signed(i_rs1_data) < $signed(i_rs2_data));
   assign lt_u = (i_rs1_data < i_rs2_data);

   always_comb begin
      case (i_dec.br_funct3)
         3'b000:  taken = eq;
         3'b001:  taken = !eq;
         3'b100:  taken = lt_s;
         3'b101:  taken = !lt_s;
         3'b110:  taken = lt_u;
         3'b111:  taken = !lt_u;
         default: taken = 1'b0;
      endcase
   end

   assign link     = i_dec.pc + 32'd4;
   assign jalr_sum = i_rs1_data + i_dec.imm;

   // JALR drops bit 0, the others are PC relative
   assign target = i_dec.is_jalr ? {jalr_sum[31:1], 1'b0} : i_dec.pc + i_dec.imm;

   always_comb begin
      o_exe          = '0;
      o_exe.value    = (i_dec.is_jal || i_dec.is_jalr) ? link : alu_res;
      o_exe.redirect = i_dec.is_jal || i_dec.is_jalr || (i_dec.is_branch && taken);
      o_exe.target   = target;
      o_exe.rd       = i_dec.rd;
      o_exe.rd_we    = i_dec.rd_we;
      o_exe.pc       = i_dec.pc;
      o_exe.illegal  = i_dec.illegal;
   end

endmodule

/* verilog/rv_fetch.sv */
module rv_fetch #(
   parameter logic [31:0] RESET_PC = 32'h0
) (
   input  logic        clk,
   input  logic        i_rst_n,
   input  logic [31:0] i_next_pc,
   input  logic        i_next_valid,
   input  logic        i_halt,
   output logic        o_wb_cyc,
   output logic        o_wb_stb,
   output logic [31:0] o_wb_adr,
   input  logic [31:0] i_wb_dat,
   input  logic        i_wb_ack,
   output logic [31:0] o_instr,
   output logic [31:0] o_instr_pc,
   output logic        o_instr_valid
);

   logic [31:0] pc;
   logic        boot;
   logic        cyc;

   // Single read per cycle, so stb follows cyc
   assign o_wb_cyc = cyc;
   assign o_wb_stb = cyc;
   assign o_wb_adr = {pc[31:2], 2'b00};

   // Word goes to decode in the cycle where ack is sampled
   assign o_instr       = i_wb_dat;
   assign o_instr_pc    = pc;
   assign o_instr_valid = cyc & i_wb_ack;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pc   <= RESET_PC;
         boot <= 1'b1;
         cyc  <= 1'b0;
      end else begin
         boot <= 1'b0;
         if (i_next_valid) begin
            pc <= i_next_pc;
         end
         if (cyc && i_wb_ack) begin
            cyc <= 1'b0;
         end else if (!i_halt && (boot || i_next_valid)) begin
            // First fetch after reset, or the next one after a commit
            cyc <= 1'b1;
         end
      end
   end

endmodule

/* verilog/rv_pkg.sv */
package rv_pkg;

   // Major opcode, instruction bits 6:2
   typedef enum logic [4:0] {
      OPC_OP     = 5'b01100,
      OPC_OP_IMM = 5'b00100,
      OPC_LUI    = 5'b01101,
      OPC_AUIPC  = 5'b00101,
      OPC_JAL    = 5'b11011,
      OPC_JALR   = 5'b11001,
      OPC_BRANCH = 5'b11000
   } rv_opcode_e;

   typedef enum logic [3:0] {
      ALU_ADD    = 4'd0,
      ALU_SUB    = 4'd1,
      ALU_SLL    = 4'd2,
      ALU_SLT    = 4'd3,
      ALU_SLTU   = 4'd4,
      ALU_XOR    = 4'd5,
      ALU_SRL    = 4'd6,
      ALU_SRA    = 4'd7,
      ALU_OR     = 4'd8,
      ALU_AND    = 4'd9,
      ALU_PASS_B = 4'd10
   } rv_alu_op_e;

   // One decoded instruction, valid for a single cycle after the latch
   typedef struct packed {
      logic        valid;
      rv_alu_op_e  alu_op;
      logic        op_a_pc;
      logic        op_b_imm;
      logic        is_branch;
      logic        is_jal;
      logic        is_jalr;
      logic [2:0]  br_funct3;
      logic        rd_we;
      logic [4:0]  rd;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic [31:0] imm;
      logic [31:0] pc;
      logic        illegal;
   } rv_dec_t;

   typedef struct packed {
      logic [31:0] value;
      logic        redirect;
      logic [31:0] target;
      logic [4:0]  rd;
      logic        rd_we;
      logic [31:0] pc;
      logic        illegal;
   } rv_exe_t;

endpackage

/* verilog/rv_regfile.sv */
module rv_regfile (
   input  logic        clk,
   input  logic        i_rst_n,
   input  logic [4:0]  i_rs1,
   input  logic [4:0]  i_rs2,
   output logic [31:0] o_rs1_data,
   output logic [31:0] o_rs2_data,
   input  logic        i_we,
   input  logic [4:0]  i_rd,
   input  logic [31:0] i_rd_data
);

   // x0 has no storage
   logic [31:0] regs [31:1];

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= 32'h0;
         end
      end else if (i_we && i_rd != 5'd0) begin
         regs[i_rd] <= i_rd_data;
      end
   end

   // Combinational read ports
   always_comb begin
      o_rs1_data = 32'h0;
      o_rs2_data = 32'h0;
      if (i_rs1 != 5'd0) begin
         o_rs1_data = regs[i_rs1];
      end
      if (i_rs2 != 5'd0) begin
         o_rs2_data = regs[i_rs2];
      end
   end

endmodule

/* verilog/rv_result.sv */
module rv_result #(
   parameter logic [31:0] RESET_PC = 32'h0
) (
   input  logic             clk,
   input  logic             i_rst_n,
   input  rv_pkg::rv_exe_t  i_exe,
   input  logic             i_commit,
   output logic             o_rf_we,
   output logic [4:0]       o_rf_rd,
   output logic [31:0]      o_rf_data,
   output logic [31:0]      o_next_pc,
   output logic             o_next_valid,
   output logic             o_retire,
   output logic [31:0]      o_retire_pc,
   output logic [4:0]       o_retire_rd,
   output logic [31:0]      o_retire_data,
   output logic             o_halt
);

   logic commit;
   logic wr_en;

   // Nothing commits once the core has stopped
   assign commit = i_commit && !o_halt;
   assign wr_en  = commit && i_exe.rd_we && !i_exe.illegal;

   // Register file write lands on the commit edge
   assign o_rf_we   = wr_en;
   assign o_rf_rd   = i_exe.rd;
   assign o_rf_data = i_exe.value;

   assign o_next_pc    = i_exe.redirect ? i_exe.target : i_exe.pc + 32'd4;
   assign o_next_valid = commit && !i_exe.illegal;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_retire      <= 1'b0;
         o_halt        <= 1'b0;
         o_retire_pc   <= RESET_PC;
         o_retire_rd   <= 5'd0;
         o_retire_data <= 32'h0;
      end else begin
         o_retire <= commit;
         if (commit) begin
            o_retire_pc   <= i_exe.pc;
            o_retire_rd   <= wr_en ? i_exe.rd : 5'd0;
            o_retire_data <= wr_en ? i_exe.value : 32'h0;
            // Sticky, the illegal word retires with halt already high
            if (i_exe.illegal) begin
               o_halt <= 1'b1;
            end
         end
      end
   end

endmodule
